// ==== mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

  // Bus geometry
  localparam int addr_w  = 16;
  localparam int data_w  = 32;
  localparam int strb_w  = data_w / 8;
  localparam int page_lsb = 12;               // Page select starts here
  localparam int page_w  = addr_w - page_lsb;

  // Page map, bits 15:12
  localparam logic [page_w-1:0] page_ledsw = 4'd0;
  localparam logic [page_w-1:0] page_uart  = 4'd1;

  // Byte offsets inside a page
  localparam logic [page_lsb-1:0] reg_led     = 12'h000;
  localparam logic [page_lsb-1:0] reg_inputs  = 12'h004;
  localparam logic [page_lsb-1:0] reg_txdata  = 12'h000;
  localparam logic [page_lsb-1:0] reg_divisor = 12'h004;
  localparam logic [page_lsb-1:0] reg_status  = 12'h008;

  // Reset values
  localparam logic [15:0] divisor_reset = 16'd16; // Clocks per bit
  localparam logic [17:0] led_reset     = 18'h0;

  // 8N1 frame, start + 8 data + stop
  localparam int frame_bits = 10;

  // AXI response codes
  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  // Slave port states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_issue = 2'd1;  // Request valid on the bus
  localparam logic [1:0] st_resp  = 2'd2;  // B or R held until accepted

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [addr_w-1:2] addr;   // Word address
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] mask;   // Zero on reads
  } mmio_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              error;  // Unmapped page
  } mmio_rsp_t;

endpackage

`default_nettype wire

// ==== mmio_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_axil_slave (
  input  logic                        clkrst_core_clk,
  input  logic                        rst,
  input  logic [mmio_pkg::addr_w-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [mmio_pkg::data_w-1:0] wdata,
  input  logic [mmio_pkg::strb_w-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [mmio_pkg::addr_w-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [mmio_pkg::data_w-1:0] rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output mmio_pkg::mmio_req_t         req,
  input  mmio_pkg::mmio_rsp_t         rsp
);
  import mmio_pkg::*;

  logic [1:0]        state_q;
  logic              prio_rd_q;  // Read takes the next tie
  logic              wr_elig;
  logic              rd_elig;
  logic              grant_wr;
  logic              grant_rd;
  logic              resp_done;
  logic [1:0]        resp_code;
  logic              wr_q;       // Transaction in flight is a write
  logic [addr_w-1:2] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [strb_w-1:0] mask_q;

  // Both AW and W must be there, no half-accepted writes
  assign wr_elig  = awvalid & wvalid & (state_q == st_idle);
  assign rd_elig  = arvalid & (state_q == st_idle);
  assign grant_wr = wr_elig & (~rd_elig | ~prio_rd_q);
  assign grant_rd = rd_elig & (~wr_elig | prio_rd_q);

  assign awready = grant_wr;
  assign wready  = grant_wr;  // Pulses with awready
  assign arready = grant_rd;

  assign resp_done = wr_q ? bready : rready;

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      state_q   <= st_idle;
      prio_rd_q <= 1'b0;      // Write wins the first tie
    end else begin
      case (state_q)
        st_idle:  if (grant_wr | grant_rd) state_q <= st_issue;
        st_issue: state_q <= st_resp;  // Decoder registers rsp here
        st_resp:  if (resp_done) state_q <= st_idle;
        default:  state_q <= st_idle;
      endcase
      if (wr_elig & rd_elig)
        prio_rd_q <= ~prio_rd_q;  // Loser of this tie wins the next
    end
  end

  // Payload capture at acceptance
  always_ff @(posedge clkrst_core_clk) begin
    if (grant_wr) begin
      wr_q    <= 1'b1;
      addr_q  <= awaddr[addr_w-1:2];
      wdata_q <= wdata;
      mask_q  <= wstrb;
    end else if (grant_rd) begin
      wr_q    <= 1'b0;
      addr_q  <= araddr[addr_w-1:2];
      wdata_q <= '0;
      mask_q  <= '0;           // Reads carry no byte mask
    end
  end

  // Single-cycle request on the register bus
  assign req = '{valid: (state_q == st_issue), write: wr_q, addr: addr_q,
                 wdata: wdata_q, mask: mask_q};

  assign resp_code = rsp.error ? axi_resp_slverr : axi_resp_okay;

  // rsp is held by the decoder until the next request
  assign bvalid = (state_q == st_resp) & wr_q;
  assign rvalid = (state_q == st_resp) & ~wr_q;
  assign bresp  = resp_code;
  assign rresp  = resp_code;
  assign rdata  = rsp.rdata;

endmodule

`default_nettype wire

// ==== mmio_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_decode (
  input  logic                        clkrst_core_clk,
  input  logic                        rst,
  input  mmio_pkg::mmio_req_t         req,
  output mmio_pkg::mmio_rsp_t         rsp,
  output mmio_pkg::mmio_req_t         ledsw_req,
  input  logic [mmio_pkg::data_w-1:0] ledsw_rdata,
  output mmio_pkg::mmio_req_t         uart_req,
  input  logic [mmio_pkg::data_w-1:0] uart_rdata
);
  import mmio_pkg::*;

  logic [page_w-1:0] page;
  logic              hit_ledsw;
  logic              hit_uart;
  logic              miss;
  logic [data_w-1:0] sel_rdata;

  assign page      = req.addr[addr_w-1:page_lsb];  // Bits 15:12
  assign hit_ledsw = (page == page_ledsw);
  assign hit_uart  = (page == page_uart);
  assign miss      = ~(hit_ledsw | hit_uart);

  // Same request to every peripheral, valid only where the page matches
  always_comb begin
    ledsw_req       = req;
    ledsw_req.valid = req.valid & hit_ledsw;
    uart_req        = req;
    uart_req.valid  = req.valid & hit_uart;
  end

  // Read mux, zero on a miss
  always_comb begin
    if (hit_ledsw)
      sel_rdata = ledsw_rdata;
    else if (hit_uart)
      sel_rdata = uart_rdata;
    else
      sel_rdata = '0;
  end

  // Response one cycle after the request, held until the next one
  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      rsp <= '0;
    end else if (req.valid) begin
      rsp.rdata <= sel_rdata;
      rsp.error <= miss;  // Becomes SLVERR at the slave port
    end
  end

endmodule

`default_nettype wire

// ==== mmio_ledsw.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_ledsw (
  input  logic                        clkrst_core_clk,
  input  logic                        rst,
  input  mmio_pkg::mmio_req_t         req,
  output logic [mmio_pkg::data_w-1:0] rdata,
  input  logic [9:0]                  switches,
  input  logic [3:0]                  buttons,
  output logic [7:0]                  led_g,
  output logic [9:0]                  led_r
);
  import mmio_pkg::*;

  logic [page_lsb-1:0] offset;
  logic                led_wr;
  logic [17:0]         led_q;      // led_r in 17:8, led_g in 7:0
  logic [9:0]          sw_meta;
  logic [9:0]          sw_sync;
  logic [3:0]          btn_meta;
  logic [3:0]          btn_sync;

  assign offset = {req.addr[page_lsb-1:2], 2'b00};
  assign led_wr = req.valid & req.write & (offset == reg_led);

  // Byte-masked LED update, byte 3 has no bits behind it
  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      led_q <= led_reset;
    end else if (led_wr) begin
      if (req.mask[0]) led_q[7:0]   <= req.wdata[7:0];
      if (req.mask[1]) led_q[15:8]  <= req.wdata[15:8];
      if (req.mask[2]) led_q[17:16] <= req.wdata[17:16];
    end
  end

  // Two-flop synchronizers for the async pins
  always_ff @(posedge clkrst_core_clk) begin
    sw_meta  <= switches;
    sw_sync  <= sw_meta;
    btn_meta <= buttons;
    btn_sync <= btn_meta;
  end

  // Readback, reg_inputs is read only
  always_comb begin
    case (offset)
      reg_led:    rdata = {{(data_w-18){1'b0}}, led_q};
      reg_inputs: rdata = {{(data_w-14){1'b0}}, btn_sync, sw_sync};
      default:    rdata = '0;
    endcase
  end

  assign led_g = led_q[7:0];
  assign led_r = led_q[17:8];

endmodule

`default_nettype wire

// ==== mmio_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_uart_tx (
  input  logic                        clkrst_core_clk,
  input  logic                        rst,
  input  mmio_pkg::mmio_req_t         req,
  output logic [mmio_pkg::data_w-1:0] rdata,
  output logic                        uart_tx
);
  import mmio_pkg::*;

  logic [page_lsb-1:0]   offset;
  logic                  wr_en;
  logic                  start;
  logic [15:0]           divisor_q;   // Clocks per bit
  logic                  busy_q;
  logic [15:0]           cyc_q;       // Clocks into the current bit
  logic [3:0]            bit_q;       // Bit index in the frame
  logic [frame_bits-1:0] shift_q;     // LSB is on the line
  logic                  bit_end;

  assign offset = {req.addr[page_lsb-1:2], 2'b00};
  assign wr_en  = req.valid & req.write;
  // Dropped when a frame is already going out
  assign start  = wr_en & (offset == reg_txdata) & req.mask[0] & ~busy_q;

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      divisor_q <= divisor_reset;
    end else if (wr_en && offset == reg_divisor) begin
      if (req.mask[0]) divisor_q[7:0]  <= req.wdata[7:0];
      if (req.mask[1]) divisor_q[15:8] <= req.wdata[15:8];
    end
  end

  assign bit_end = (cyc_q == divisor_q - 16'd1);

  // Bit timing and frame control
  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cyc_q  <= '0;
      bit_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;  // Start bit on the line next cycle
      cyc_q  <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        cyc_q <= '0;
        if (bit_q == 4'(frame_bits - 1))
          busy_q <= 1'b0;  // Stop bit done
        else
          bit_q <= bit_q + 4'd1;
      end else begin
        cyc_q <= cyc_q + 16'd1;
      end
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clkrst_core_clk) begin
    if (start)
      shift_q <= {1'b1, req.wdata[7:0], 1'b0};
    else if (busy_q && bit_end)
      shift_q <= {1'b1, shift_q[frame_bits-1:1]};
  end

  assign uart_tx = busy_q ? shift_q[0] : 1'b1;  // Idles high

  always_comb begin
    case (offset)
      reg_divisor: rdata = {{(data_w-16){1'b0}}, divisor_q};
      reg_status:  rdata = {{(data_w-1){1'b0}}, busy_q};
      default:     rdata = '0;  // txdata is write only
    endcase
  end

endmodule

`default_nettype wire

// ==== mmio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_top (
  input  logic                        clkrst_core_clk,
  input  logic                        rst,
  input  logic [mmio_pkg::addr_w-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [mmio_pkg::data_w-1:0] wdata,
  input  logic [mmio_pkg::strb_w-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [mmio_pkg::addr_w-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [mmio_pkg::data_w-1:0] rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  input  logic [9:0]                  switches,
  input  logic [3:0]                  buttons,
  output logic [7:0]                  led_g,
  output logic [9:0]                  led_r,
  output logic                        uart_tx
);
  import mmio_pkg::*;

  mmio_req_t         bus_req;      // Slave port to decoder
  mmio_rsp_t         bus_rsp;
  mmio_req_t         ledsw_req;
  mmio_req_t         uart_req;
  logic [data_w-1:0] ledsw_rdata;
  logic [data_w-1:0] uart_rdata;

  mmio_axil_slave i_mmio_axil_slave (
    .clkrst_core_clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .req (bus_req),
    .rsp (bus_rsp)
  );

  mmio_decode i_mmio_decode (
    .clkrst_core_clk, .rst,
    .req (bus_req),
    .rsp (bus_rsp),
    .ledsw_req, .ledsw_rdata,
    .uart_req, .uart_rdata
  );

  mmio_ledsw i_mmio_ledsw (
    .clkrst_core_clk, .rst,
    .req   (ledsw_req),
    .rdata (ledsw_rdata),
    .switches, .buttons, .led_g, .led_r
  );

  mmio_uart_tx i_mmio_uart_tx (
    .clkrst_core_clk, .rst,
    .req   (uart_req),
    .rdata (uart_rdata),
    .uart_tx
  );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  initial clk = 1'b0;

  always #5 clk = ~clk;  // 10 ns period

endmodule

`default_nettype wire

// ==== mmio_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_asserts (
  input logic                clkrst_core_clk,
  input logic                rst,
  input logic                awvalid,
  input logic                wvalid,
  input logic                awready,
  input logic                arready,
  input logic                bvalid,
  input logic                bready,
  input logic                rvalid,
  input logic                rready,
  input mmio_pkg::mmio_req_t req
);

  // AW and W are only taken together, from an idle port and never with a read
  aw_with_w: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    awready |-> (awvalid && wvalid && !arready && !req.valid && !bvalid && !rvalid))
    else $error("awready high without both valids or while the port is busy");

  // Responses held until the master takes them
  b_hold: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    (rvalid && !rready) |=> rvalid)
    else $error("rvalid dropped before rready");

  // One bus cycle per transaction
  req_pulse: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    req.valid |=> !req.valid)
    else $error("register bus request valid longer than one cycle");

endmodule

bind mmio_axil_slave mmio_asserts i_mmio_asserts (
  .clkrst_core_clk, .rst,
  .awvalid, .wvalid, .awready, .arready,
  .bvalid, .bready, .rvalid, .rready,
  .req
);

`default_nettype wire

// ==== mmio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_tb;
  import mmio_pkg::*;

  localparam int wait_limit = 50;  // Cycles per wait loop

  logic              clkrst_core_clk;
  logic              rst;
  logic [addr_w-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [data_w-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic [9:0]        switches;
  logic [3:0]        buttons;
  logic [7:0]        led_g;
  logic [9:0]        led_r;
  logic              uart_tx;

  logic [31:0] lfsr_q;
  int          err_value;   // Wrong values
  int          err_other;   // Timeouts
  logic [17:0] led_exp;     // LED register model
  logic [15:0] div_exp;     // Divisor model

  tb_clkgen i_tb_clkgen (.clk(clkrst_core_clk));

  mmio_top i_mmio_top (.*);

  // Right-shift Galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
    end
    return v;
  endfunction

  task automatic check_data(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      err_value++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    err_other++;
  endtask

  // Drive on negedge, sample 1 ns later
  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int n;
    int lat;
    @(negedge clkrst_core_clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    #1;
    n = 0;
    while (!awready && n < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      n++;
    end
    if (!awready)
      note_timeout("awready");
    else
      check_byte("wready", {7'b0, wready}, 8'h01);  // Pulses with awready
    @(negedge clkrst_core_clk);  // Accepted on the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    #1;
    lat = 1;
    while (!bvalid && lat < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      lat++;
    end
    if (!bvalid) note_timeout("bvalid");
    check_data("write latency", 32'(lat), 32'd2);
    resp = bresp;
    @(negedge clkrst_core_clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    int lat;
    @(negedge clkrst_core_clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    #1;
    n = 0;
    while (!arready && n < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      n++;
    end
    if (!arready) note_timeout("arready");
    @(negedge clkrst_core_clk);
    arvalid = 1'b0;
    #1;
    lat = 1;
    while (!rvalid && lat < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      lat++;
    end
    if (!rvalid) note_timeout("rvalid");
    check_data("read latency", 32'(lat), 32'd2);
    data = rdata;
    resp = rresp;
    @(negedge clkrst_core_clk);
    rready = 1'b0;
  endtask

  task automatic check_leds();
    check_byte("led_g", led_g, led_exp[7:0]);
    check_data("led_r", {22'b0, led_r}, {22'b0, led_exp[17:8]});
  endtask

  task automatic test_reset_values();
    @(negedge clkrst_core_clk);
    #1;
    check_byte("awready after reset", {7'b0, awready}, 8'h00);
    check_byte("wready after reset", {7'b0, wready}, 8'h00);
    check_byte("arready after reset", {7'b0, arready}, 8'h00);
    check_byte("bvalid after reset", {7'b0, bvalid}, 8'h00);
    check_byte("rvalid after reset", {7'b0, rvalid}, 8'h00);
    check_byte("uart_tx idle", {7'b0, uart_tx}, 8'h01);
    check_leds();
  endtask

  task automatic test_led_mask();
    logic [31:0] d;
    logic [3:0]  s;
    logic [31:0] rd;
    logic [1:0]  r;
    for (int i = 0; i < 8; i++) begin
      d = rand_bits(32);
      s = 4'(rand_bits(4));
      axil_write({page_ledsw, reg_led}, d, s, r);
      check_resp("bresp led", r, axi_resp_okay);
      if (s[0]) led_exp[7:0] = d[7:0];
      if (s[1]) led_exp[15:8] = d[15:8];
      if (s[2]) led_exp[17:16] = d[17:16];  // Only two bits live in byte 2
      check_leds();
      axil_read({page_ledsw, reg_led}, rd, r);
      check_data("reg_led", rd, {14'b0, led_exp});
      check_resp("rresp led", r, axi_resp_okay);
    end
  endtask

  task automatic test_inputs();
    logic [9:0]  sw;
    logic [3:0]  bt;
    logic [31:0] rd;
    logic [1:0]  r;
    for (int i = 0; i < 4; i++) begin
      sw = 10'(rand_bits(10));
      bt = 4'(rand_bits(4));
      @(negedge clkrst_core_clk);
      switches = sw;
      buttons  = bt;
      repeat (3) @(negedge clkrst_core_clk);  // Through the synchronizers
      axil_read({page_ledsw, reg_inputs}, rd, r);
      check_data("reg_inputs", rd, {18'b0, bt, sw});
      check_resp("rresp inputs", r, axi_resp_okay);
    end
  endtask

  // Samples each bit in its middle, counted from the start edge
  task automatic uart_capture(input int div, output logic [7:0] data);
    int         n;
    logic [9:0] frame;
    n = 0;
    data = '0;
    @(negedge clkrst_core_clk);
    while (uart_tx !== 1'b0 && n < wait_limit) begin
      @(negedge clkrst_core_clk);
      n++;
    end
    if (uart_tx !== 1'b0) begin
      note_timeout("UART start bit");
      return;
    end
    repeat ((div - 1) / 2) @(negedge clkrst_core_clk);
    frame[0] = uart_tx;
    for (int i = 1; i < 10; i++) begin
      repeat (div) @(negedge clkrst_core_clk);
      frame[i] = uart_tx;
    end
    check_byte("uart start bit", {7'b0, frame[0]}, 8'h00);
    check_byte("uart stop bit", {7'b0, frame[9]}, 8'h01);
    data = frame[8:1];  // LSB first on the line
  endtask

  task automatic test_uart();
    logic [7:0]  tx_byte;
    logic [7:0]  got;
    logic [31:0] rd;
    logic [1:0]  r;
    int          low_cnt;
    div_exp = 16'd4 + 16'(rand_bits(4));  // 4 to 19
    tx_byte = 8'(rand_bits(8));
    // Upper half is masked off
    axil_write({page_uart, reg_divisor}, {16'(rand_bits(16)), div_exp}, 4'b0011, r);
    check_resp("bresp divisor", r, axi_resp_okay);
    axil_read({page_uart, reg_divisor}, rd, r);
    check_data("reg_divisor", rd, {16'b0, div_exp});
    fork
      uart_capture(int'(div_exp), got);
      begin
        axil_write({page_uart, reg_txdata}, {24'b0, tx_byte}, 4'b1111, r);
        check_resp("bresp txdata", r, axi_resp_okay);
        axil_read({page_uart, reg_status}, rd, r);
        check_data("reg_status busy", rd, 32'd1);
        // Lands mid-frame, must not be sent
        axil_write({page_uart, reg_txdata}, {24'b0, ~tx_byte}, 4'b1111, r);
      end
    join
    check_byte("uart data", got, tx_byte);
    low_cnt = 0;
    repeat (12 * int'(div_exp)) begin
      @(negedge clkrst_core_clk);
      if (uart_tx !== 1'b1) low_cnt++;
    end
    check_data("uart_tx low samples after frame", 32'(low_cnt), 32'd0);
    axil_read({page_uart, reg_status}, rd, r);
    check_data("reg_status idle", rd, 32'd0);
  endtask

  task automatic test_decode_miss();
    logic [31:0] rd;
    logic [1:0]  r;
    axil_write({4'd5, 12'h000}, rand_bits(32), 4'b1111, r);
    check_resp("bresp page 5", r, axi_resp_slverr);
    axil_read({4'd5, 12'h004}, rd, r);
    check_resp("rresp page 5", r, axi_resp_slverr);
    check_data("rdata page 5", rd, 32'd0);
    check_leds();  // Miss leaves the LEDs alone
  endtask

  task automatic test_backpressure();
    logic [31:0] d;
    logic [31:0] rd;
    logic [1:0]  r;
    int          n;
    d = rand_bits(32);
    @(negedge clkrst_core_clk);
    awaddr  = {page_ledsw, reg_led};
    wdata   = d;
    wstrb   = 4'b1111;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    #1;
    n = 0;
    while (!awready && n < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      n++;
    end
    if (!awready) note_timeout("awready under back-pressure");
    @(negedge clkrst_core_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    araddr  = {page_uart, reg_divisor};
    arvalid = 1'b1;  // Must stall behind the pending B
    #1;
    n = 0;
    while (!bvalid && n < wait_limit) begin
      @(negedge clkrst_core_clk);
      #1;
      n++;
    end
    if (!bvalid) note_timeout("bvalid under back-pressure");
    led_exp = d[17:0];
    repeat (5) begin
      @(negedge clkrst_core_clk);
      #1;
      check_byte("bvalid held", {7'b0, bvalid}, 8'h01);
      check_byte("arready stalled", {7'b0, arready}, 8'h00);
    end
    @(negedge clkrst_core_clk);
    arvalid = 1'b0;
    bready  = 1'b1;
    #1;
    check_resp("bresp after stall", bresp, axi_resp_okay);
    @(negedge clkrst_core_clk);
    bready = 1'b0;
    check_leds();
    axil_read({page_uart, reg_divisor}, rd, r);
    check_data("reg_divisor after stall", rd, {16'b0, div_exp});
  endtask

  // Write and read raised together, reports which response came first
  task automatic tie_pair(output logic wr_first);
    logic [31:0] d;
    logic        aw_done;
    logic        ar_done;
    logic        b_done;
    logic        r_done;
    int          n;
    d        = rand_bits(32);
    aw_done  = 1'b0;
    ar_done  = 1'b0;
    b_done   = 1'b0;
    r_done   = 1'b0;
    wr_first = 1'b0;
    @(negedge clkrst_core_clk);
    awaddr  = {page_ledsw, reg_led};
    wdata   = d;
    wstrb   = 4'b1111;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    araddr  = {page_uart, reg_divisor};
    arvalid = 1'b1;
    bready  = 1'b1;
    rready  = 1'b1;
    #1;
    check_byte("one grant on tie", {7'b0, awready ^ arready}, 8'h01);
    n = 0;
    while (!(b_done && r_done) && n < 2 * wait_limit) begin
      if (awready) aw_done = 1'b1;
      if (arready) ar_done = 1'b1;
      if (bvalid && !b_done) begin
        b_done   = 1'b1;
        wr_first = !r_done;
        check_resp("bresp tie", bresp, axi_resp_okay);
      end
      if (rvalid && !r_done) begin
        r_done = 1'b1;
        check_data("rdata tie", rdata, {16'b0, div_exp});
        check_resp("rresp tie", rresp, axi_resp_okay);
      end
      @(negedge clkrst_core_clk);
      if (aw_done) begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
      end
      if (ar_done) arvalid = 1'b0;
      #1;
      n++;
    end
    if (!(b_done && r_done)) note_timeout("both responses of a tie");
    @(negedge clkrst_core_clk);
    bready = 1'b0;
    rready = 1'b0;
    led_exp = d[17:0];
    check_leds();
  endtask

  task automatic test_arbitration();
    logic first_a;
    logic first_b;
    tie_pair(first_a);
    tie_pair(first_b);
    check_byte("second tie winner", {7'b0, first_b}, {7'b0, ~first_a});
  endtask

  initial begin
    lfsr_q    = 32'h3bf870d5;
    err_value = 0;
    err_other = 0;
    rst       = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    switches  = '0;
    buttons   = '0;
    led_exp   = '0;
    div_exp   = divisor_reset;
    repeat (10) @(negedge clkrst_core_clk);
    rst = 1'b0;
    test_reset_values();
    test_led_mask();
    test_inputs();
    test_uart();
    test_decode_miss();
    test_backpressure();
    test_arbitration();
    repeat (5) @(negedge clkrst_core_clk);
    $display("Errors: %0d value mismatches, %0d timeouts", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
mmio_pkg.sv
mmio_axil_slave.sv
mmio_decode.sv
mmio_ledsw.sv
mmio_uart_tx.sv
mmio_top.sv
tb_clkgen.sv
mmio_asserts.sv
mmio_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log

verilator --binary --timing --assert --top-module mmio_tb -f files.f -o vmmio_tb &&
  ./obj_dir/vmmio_tb > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
